// File: src/clk_mon_cfg_pkg.sv
// measurement configuration package
// window, count, sample and history widths plus watchdog length

`default_nettype none

package clk_mon_cfg_pkg;

  // ************************************************
  // measurement window
  // ************************************************

  // window counter width
  // one window lasts 2**win_width - 1 up_clk cycles
  localparam int win_width = 10;

  // window length in up_clk cycles
  localparam int win_cycles = (2 ** win_width) - 1;

  // raw device count carries one extra bit to flag saturation
  localparam int count_width = 33;

  // reported sample is the low part of the saturated count
  localparam int sample_width = 32;

  // ************************************************
  // history and watchdog
  // ************************************************

  localparam int hist_depth = 4;
  localparam int hist_idx_width = 2;

  // window lengths without a sample before the clock is lost
  localparam int lost_windows = 3;
  localparam int wdog_cycles = lost_windows * win_cycles;
  localparam int wdog_width = $clog2(wdog_cycles + 1);

  // free running sample counter wraps at this width
  localparam int samp_cnt_width = 8;

endpackage

`default_nettype wire

// File: src/clk_mon_reg_pkg.sv
// register map package
// register address enum, monitor state enum and bus data width

`default_nettype none

package clk_mon_reg_pkg;

  // ************************************************
  // register port
  // ************************************************

  // register data width
  localparam int data_width = 32;

  // register address width
  localparam int addr_width = 4;

  // register addresses
  // history block sits on an aligned base so the low bits give the index
  typedef enum logic [addr_width-1:0] {
    // latest sample, read only
    addr_count     = 4'h0,
    // limits, read and write
    addr_limit_min = 4'h1,
    addr_limit_max = 4'h2,
    // state, fault and sample count, read only
    addr_status    = 4'h3,
    // write only, clears the sticky fault
    addr_clear     = 4'h4,
    // history, newest first
    addr_hist0     = 4'h8,
    addr_hist1     = 4'h9,
    addr_hist2     = 4'ha,
    addr_hist3     = 4'hb
  } clk_mon_addr_e;

  // ************************************************
  // monitor state
  // ************************************************

  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_locked = 2'd1,
    st_fault  = 2'd2,
    st_lost   = 2'd3
  } clk_mon_state_e;

endpackage

`default_nettype wire

// File: src/clk_mon_counter.sv
// window counter across the up_clk and d_clk domains
// up_clk reset synchronizer and one frequency sample per window

`timescale 1ns/1ps
`default_nettype none

module clk_mon_counter (
  input  wire                                    up_clk,
  input  wire                                    d_clk,
  input  wire                                    d_rst,
  output logic                                   up_rst,
  output logic [clk_mon_cfg_pkg::sample_width-1:0] sample,
  output logic                                   sample_valid
);

  // processor side state
  logic                                    up_rst_m1;
  logic [clk_mon_cfg_pkg::win_width-1:0]   up_count;
  logic                                    up_count_run;
  // echo of the device run level, [2] is the oldest stage
  logic [2:0]                              up_run_echo;
  logic                                    up_capture;

  // device side state
  logic [2:0]                              d_run_sync;
  logic                                    d_count_clr;
  logic [clk_mon_cfg_pkg::count_width-1:0] d_count;

  // ************************************************
  // processor domain
  // ************************************************

  // reset asserts at once and releases on up_clk
  always_ff @(posedge up_clk or posedge d_rst) begin
    if (d_rst) begin
      up_rst_m1 <= 1'b1;
      up_rst <= 1'b1;
    end else begin
      up_rst_m1 <= 1'b0;
      up_rst <= up_rst_m1;
    end
  end

  // device run level comes back over three flops
  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      up_run_echo <= 3'b000;
    end else begin
      up_run_echo <= {up_run_echo[1:0], d_run_sync[2]};
    end
  end

  // falling echo means the device count has stopped and is stable
  assign up_capture = up_run_echo[2] & ~up_run_echo[1];

  // run rises once the echo is low and falls when the window wraps
  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      up_count_run <= 1'b0;
      up_count <= 1;
    end else begin
      if (!up_run_echo[2]) begin
        up_count_run <= 1'b1;
      end else if (up_count == '0) begin
        up_count_run <= 1'b0;
      end
      // window counter restarts from one while run is low
      if (!up_count_run) begin
        up_count <= 1;
      end else begin
        up_count <= up_count + 1'b1;
      end
    end
  end

  // sample and its strobe leave on the same edge
  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      sample <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= up_capture;
      if (up_capture) begin
        // top bit set means the count saturated
        sample <= d_count[clk_mon_cfg_pkg::count_width-1] ? '1 :
                  d_count[clk_mon_cfg_pkg::sample_width-1:0];
      end
    end
  end

  // ************************************************
  // device domain
  // ************************************************

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      d_run_sync <= 3'b000;
    end else begin
      d_run_sync <= {d_run_sync[1:0], up_count_run};
    end
  end

  // rising run starts a fresh count
  assign d_count_clr = d_run_sync[1] & ~d_run_sync[2];

  // count edges while run is high and hold at all ones
  always_ff @(posedge d_clk) begin
    if (d_count_clr) begin
      d_count <= '0;
    end else if (d_run_sync[2] && !(&d_count)) begin
      d_count <= d_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/clk_mon_history.sv
// sample history with a running sample count
// four-entry circular store, index 0 reads the newest entry

`timescale 1ns/1ps
`default_nettype none

module clk_mon_history (
  input  wire                                        up_clk,
  input  wire                                        up_rst,
  input  wire  [clk_mon_cfg_pkg::sample_width-1:0]   sample,
  input  wire                                        sample_valid,
  input  wire  [clk_mon_cfg_pkg::hist_idx_width-1:0] hist_idx,
  output logic [clk_mon_cfg_pkg::sample_width-1:0]   hist_data,
  output logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] sample_count
);

  logic [clk_mon_cfg_pkg::sample_width-1:0]   hist_mem [clk_mon_cfg_pkg::hist_depth];
  // marks entries written since reset
  logic [clk_mon_cfg_pkg::hist_depth-1:0]     hist_vld;
  // next slot to write
  logic [clk_mon_cfg_pkg::hist_idx_width-1:0] wr_ptr;
  logic [clk_mon_cfg_pkg::hist_idx_width-1:0] rd_ptr;

  // pointers, valid flags and sample counter
  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      wr_ptr <= '0;
      hist_vld <= '0;
      sample_count <= '0;
    end else if (sample_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
      hist_vld[wr_ptr] <= 1'b1;
      // wraps freely
      sample_count <= sample_count + 1'b1;
    end
  end

  // storage
  always_ff @(posedge up_clk) begin
    if (sample_valid) begin
      hist_mem[wr_ptr] <= sample;
    end
  end

  // newest entry sits just behind the write pointer
  assign rd_ptr = wr_ptr - hist_idx - 1'b1;

  // unwritten slots read as zero
  assign hist_data = hist_vld[rd_ptr] ? hist_mem[rd_ptr] : '0;

endmodule

`default_nettype wire

// File: src/clk_mon_checker.sv
// limit checker and stopped-clock watchdog
// monitor FSM with sticky fault flag

`timescale 1ns/1ps
`default_nettype none

module clk_mon_checker (
  input  wire                                      up_clk,
  input  wire                                      up_rst,
  input  wire  [clk_mon_cfg_pkg::sample_width-1:0] sample,
  input  wire                                      sample_valid,
  input  wire  [clk_mon_cfg_pkg::sample_width-1:0] limit_min,
  input  wire  [clk_mon_cfg_pkg::sample_width-1:0] limit_max,
  input  wire                                      fault_clear,
  output clk_mon_reg_pkg::clk_mon_state_e          state,
  output logic                                     fault
);

  logic                                     in_range;
  logic                                     wdog_expired;
  logic                                     fault_set;
  logic [clk_mon_cfg_pkg::wdog_width-1:0]   wdog;
  clk_mon_reg_pkg::clk_mon_state_e          state_nxt;

  // ************************************************
  // watchdog
  // ************************************************

  // reloads on each sample, counts down to zero otherwise
  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      wdog <= clk_mon_cfg_pkg::wdog_cycles[clk_mon_cfg_pkg::wdog_width-1:0];
    end else if (sample_valid) begin
      wdog <= clk_mon_cfg_pkg::wdog_cycles[clk_mon_cfg_pkg::wdog_width-1:0];
    end else if (wdog != '0) begin
      wdog <= wdog - 1'b1;
    end
  end

  assign wdog_expired = (wdog == '0);

  // ************************************************
  // state machine
  // ************************************************

  // both limits inclusive
  assign in_range = (sample >= limit_min) && (sample <= limit_max);

  always_comb begin
    state_nxt = state;
    case (state)
      clk_mon_reg_pkg::st_lost: begin
        // only a fresh sample gets out of lost
        if (sample_valid) begin
          state_nxt = in_range ? clk_mon_reg_pkg::st_locked : clk_mon_reg_pkg::st_fault;
        end
      end
      default: begin
        // a sample wins over an expiring watchdog
        if (sample_valid) begin
          state_nxt = in_range ? clk_mon_reg_pkg::st_locked : clk_mon_reg_pkg::st_fault;
        end else if (wdog_expired) begin
          state_nxt = clk_mon_reg_pkg::st_lost;
        end
      end
    endcase
  end

  // out of range sample or newly lost clock
  assign fault_set = (sample_valid && !in_range) ||
                     (!sample_valid && wdog_expired && state != clk_mon_reg_pkg::st_lost);

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      state <= clk_mon_reg_pkg::st_idle;
      fault <= 1'b0;
    end else begin
      state <= state_nxt;
      // set has priority over clear
      if (fault_set) begin
        fault <= 1'b1;
      end else if (fault_clear) begin
        fault <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/clk_mon_regs.sv
// register block for the clock monitor
// limit registers, fault clear strobe and registered readback

`timescale 1ns/1ps
`default_nettype none

module clk_mon_regs (
  input  wire                                          up_clk,
  input  wire                                          up_rst,
  input  wire                                          wr,
  input  wire                                          rd,
  input  var   clk_mon_reg_pkg::clk_mon_addr_e         addr,
  input  wire  [clk_mon_reg_pkg::data_width-1:0]       wdata,
  input  wire  [clk_mon_cfg_pkg::sample_width-1:0]     sample,
  input  wire  [clk_mon_cfg_pkg::sample_width-1:0]     hist_data,
  input  var   clk_mon_reg_pkg::clk_mon_state_e        state,
  input  wire                                          fault,
  input  wire  [clk_mon_cfg_pkg::samp_cnt_width-1:0]   sample_count,
  output logic [clk_mon_reg_pkg::data_width-1:0]       rdata,
  output logic                                         rd_ack,
  output logic [clk_mon_cfg_pkg::hist_idx_width-1:0]   hist_idx,
  output logic [clk_mon_reg_pkg::data_width-1:0]       limit_min,
  output logic [clk_mon_reg_pkg::data_width-1:0]       limit_max,
  output logic                                         fault_clear
);

  logic [clk_mon_reg_pkg::data_width-1:0] status;
  logic [clk_mon_reg_pkg::data_width-1:0] rdata_mux;

  // history base is aligned so the low address bits select the entry
  assign hist_idx = addr[clk_mon_cfg_pkg::hist_idx_width-1:0];

  // write strobe to the clear address
  assign fault_clear = wr && (addr == clk_mon_reg_pkg::addr_clear);

  // count in 15:8, fault in 4, state in 1:0
  assign status = {16'h0000, sample_count, 3'b000, fault, 2'b00, state};

  // ************************************************
  // limits and read strobe
  // ************************************************

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      limit_min <= '0;
      limit_max <= '1;
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd;
      if (wr && addr == clk_mon_reg_pkg::addr_limit_min) begin
        limit_min <= wdata;
      end
      if (wr && addr == clk_mon_reg_pkg::addr_limit_max) begin
        limit_max <= wdata;
      end
    end
  end

  // read select
  always_comb begin
    case (addr)
      clk_mon_reg_pkg::addr_count:     rdata_mux = sample;
      clk_mon_reg_pkg::addr_limit_min: rdata_mux = limit_min;
      clk_mon_reg_pkg::addr_limit_max: rdata_mux = limit_max;
      clk_mon_reg_pkg::addr_status:    rdata_mux = status;
      clk_mon_reg_pkg::addr_hist0,
      clk_mon_reg_pkg::addr_hist1,
      clk_mon_reg_pkg::addr_hist2,
      clk_mon_reg_pkg::addr_hist3:     rdata_mux = hist_data;
      // clear and unmapped addresses read zero
      default:                         rdata_mux = '0;
    endcase
  end

  // data lines up with rd_ack
  always_ff @(posedge up_clk) begin
    if (rd) begin
      rdata <= rdata_mux;
    end
  end

endmodule

`default_nettype wire

// File: src/clk_mon_top.sv
// clock monitor top level
// counter, history, checker and register block

`timescale 1ns/1ps
`default_nettype none

module clk_mon_top (
  input  wire                                    d_clk,
  input  wire                                    d_rst,
  input  wire                                    up_clk,
  input  wire                                    wr,
  input  wire                                    rd,
  input  var   clk_mon_reg_pkg::clk_mon_addr_e   addr,
  input  wire  [clk_mon_reg_pkg::data_width-1:0] wdata,
  output logic [clk_mon_reg_pkg::data_width-1:0] rdata,
  output logic                                   rd_ack,
  output logic                                   fault
);

  // processor domain reset from the counter
  logic                                        up_rst;
  // sample path
  logic [clk_mon_cfg_pkg::sample_width-1:0]    sample;
  logic                                        sample_valid;
  // history readback
  logic [clk_mon_cfg_pkg::hist_idx_width-1:0]  hist_idx;
  logic [clk_mon_cfg_pkg::sample_width-1:0]    hist_data;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0]  sample_count;
  // checker control and status
  logic [clk_mon_reg_pkg::data_width-1:0]      limit_min;
  logic [clk_mon_reg_pkg::data_width-1:0]      limit_max;
  logic                                        fault_clear;
  clk_mon_reg_pkg::clk_mon_state_e             state;

  clk_mon_counter u_counter (
    .up_clk(up_clk), .d_clk(d_clk), .d_rst(d_rst),
    .up_rst(up_rst), .sample(sample), .sample_valid(sample_valid)
  );

  clk_mon_history u_history (
    .up_clk(up_clk), .up_rst(up_rst), .sample(sample), .sample_valid(sample_valid),
    .hist_idx(hist_idx), .hist_data(hist_data), .sample_count(sample_count)
  );

  clk_mon_checker u_checker (
    .up_clk(up_clk), .up_rst(up_rst), .sample(sample), .sample_valid(sample_valid),
    .limit_min(limit_min), .limit_max(limit_max), .fault_clear(fault_clear),
    .state(state), .fault(fault)
  );

  clk_mon_regs u_regs (
    .up_clk(up_clk), .up_rst(up_rst), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
    .sample(sample), .hist_data(hist_data), .state(state), .fault(fault),
    .sample_count(sample_count), .rdata(rdata), .rd_ack(rd_ack), .hist_idx(hist_idx),
    .limit_min(limit_min), .limit_max(limit_max), .fault_clear(fault_clear)
  );

endmodule

`default_nettype wire

// File: include/tb_clk_mon_tasks.svh
// register access, wait and compare tasks for the clock monitor testbench
// directed tests for reset, measurement, history, limits and stopped clock

`ifndef TB_CLK_MON_TASKS_SVH
`define TB_CLK_MON_TASKS_SVH

// ************************************************
// register access
// ************************************************

// one cycle write strobe
task automatic write_reg(input clk_mon_reg_pkg::clk_mon_addr_e a,
                         input logic [clk_mon_reg_pkg::data_width-1:0] d);
  @(negedge up_clk);
  wr = 1'b1;
  addr = a;
  wdata = d;
  @(negedge up_clk);
  wr = 1'b0;
endtask

// one cycle read strobe, data taken with rd_ack
task automatic read_reg(input clk_mon_reg_pkg::clk_mon_addr_e a,
                        output logic [clk_mon_reg_pkg::data_width-1:0] d);
  int n;
  n = 0;
  @(negedge up_clk);
  rd = 1'b1;
  addr = a;
  @(negedge up_clk);
  rd = 1'b0;
  while (!rd_ack && n < 8) begin
    @(negedge up_clk);
    n++;
  end
  if (rd_ack) begin
    d = rdata;
    // ack belongs one cycle after the strobe
    if (n != 0) begin
      $display("rd_ack for a read of %s came %0d cycles late at %0t ns", a.name(), n, $time);
      err_cnt++;
    end
  end else begin
    $display("rd_ack never came for a read of %s at %0t ns", a.name(), $time);
    err_cnt++;
    d = '0;
  end
endtask

// status word split into state, fault and sample count
task automatic read_status(output clk_mon_reg_pkg::clk_mon_state_e st, output logic flt,
                           output logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] cnt);
  logic [clk_mon_reg_pkg::data_width-1:0] w;
  read_reg(clk_mon_reg_pkg::addr_status, w);
  st = clk_mon_reg_pkg::clk_mon_state_e'(w[1:0]);
  flt = w[4];
  cnt = w[15:8];
endtask

// ************************************************
// waits
// ************************************************

// poll until the sample count has changed n times
task automatic wait_samples(input int n);
  clk_mon_reg_pkg::clk_mon_state_e              st;
  logic                                         flt;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0]   prev;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0]   c;
  int                                           seen;
  logic                                         stuck;
  time                                          t0;
  read_status(st, flt, prev);
  seen = 0;
  stuck = 1'b0;
  while (seen < n && !stuck) begin
    t0 = $time;
    c = prev;
    // one window per sample plus a window of slack
    while (c == prev && ($time - t0) < time'(2 * win_len * up_period)) begin
      read_status(st, flt, c);
    end
    if (c == prev) begin
      $display("sample count stuck at %0d after %0d of %0d samples at %0t ns",
               c, seen, n, $time);
      err_cnt++;
      stuck = 1'b1;
    end else begin
      prev = c;
      seen++;
    end
  end
endtask

// poll until the monitor reaches a state or the time runs out
task automatic wait_state(input clk_mon_reg_pkg::clk_mon_state_e exp, input time limit);
  clk_mon_reg_pkg::clk_mon_state_e            st;
  logic                                       flt;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] c;
  time                                        t0;
  t0 = $time;
  read_status(st, flt, c);
  while (st != exp && ($time - t0) < limit) begin
    read_status(st, flt, c);
  end
  if (st != exp) begin
    $display("monitor still in %s instead of %s at %0t ns", st.name(), exp.name(), $time);
    err_cnt++;
  end
endtask

// ************************************************
// compares
// ************************************************

task automatic expect_state(input string name, input clk_mon_reg_pkg::clk_mon_state_e got,
                            input clk_mon_reg_pkg::clk_mon_state_e exp);
  if (got !== exp) begin
    $display("ERROR at %0t ns: %s got %s expected %s", $time, name, got.name(), exp.name());
    err_cnt++;
  end
endtask

task automatic expect_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
    err_cnt++;
  end
endtask

task automatic expect_count(input string name,
                            input logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] got,
                            input logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] exp);
  if (got !== exp) begin
    $display("ERROR at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    err_cnt++;
  end
endtask

// sample within exp +/- tol
task automatic expect_sample(input string name,
                             input logic [clk_mon_cfg_pkg::sample_width-1:0] got,
                             input logic [clk_mon_cfg_pkg::sample_width-1:0] exp,
                             input int tol);
  longint diff;
  diff = longint'(got) - longint'(exp);
  if ($isunknown(got) || diff > tol || diff < -tol) begin
    $display("ERROR at %0t ns: %s got %0d expected %0d +/- %0d", $time, name, got, exp, tol);
    err_cnt++;
  end
endtask

// one line per finished test
task automatic close_test(input string name, input int err_before);
  test_cnt++;
  if (err_cnt == err_before) begin
    $display("test %s: ok", name);
  end else begin
    test_fail++;
    $display("test %s: %0d errors", name, err_cnt - err_before);
  end
endtask

// ************************************************
// directed tests
// ************************************************

// idle state, no fault, zero count and default limits
task automatic reset_values();
  int                                         e0;
  clk_mon_reg_pkg::clk_mon_state_e            st;
  logic                                       flt;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] cnt;
  logic [clk_mon_reg_pkg::data_width-1:0]     d;
  e0 = err_cnt;
  expect_flag("rd_ack", rd_ack, 1'b0);
  read_status(st, flt, cnt);
  expect_state("state", st, clk_mon_reg_pkg::st_idle);
  expect_flag("status fault", flt, 1'b0);
  expect_flag("fault", fault, 1'b0);
  expect_count("sample_count", cnt, '0);
  read_reg(clk_mon_reg_pkg::addr_count, d);
  expect_sample("count", d, '0, 0);
  read_reg(clk_mon_reg_pkg::addr_limit_min, d);
  expect_sample("limit_min", d, '0, 0);
  read_reg(clk_mon_reg_pkg::addr_limit_max, d);
  expect_sample("limit_max", d, '1, 0);
  close_test("reset", e0);
endtask

// latest sample after two windows
task automatic measure_window();
  int                                     e0;
  logic [clk_mon_reg_pkg::data_width-1:0] d;
  e0 = err_cnt;
  wait_samples(2);
  read_reg(clk_mon_reg_pkg::addr_count, d);
  expect_sample("count", d, exp_sample, sample_tol);
  close_test("measurement", e0);
endtask

// four fresh entries and a count that moved by four
task automatic history_entries();
  int                                         e0;
  int                                         i;
  clk_mon_reg_pkg::clk_mon_state_e            st;
  logic                                       flt;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] c0;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] c1;
  logic [clk_mon_reg_pkg::data_width-1:0]     d;
  e0 = err_cnt;
  read_status(st, flt, c0);
  wait_samples(4);
  for (i = 0; i < clk_mon_cfg_pkg::hist_depth; i++) begin
    read_reg(clk_mon_reg_pkg::clk_mon_addr_e'(clk_mon_reg_pkg::addr_hist0 + i), d);
    expect_sample($sformatf("hist%0d", i), d, exp_sample, sample_tol);
  end
  read_status(st, flt, c1);
  expect_count("sample_count", c1, c0 + 8'd4);
  close_test("history", e0);
endtask

// in range, out of range, then recovery through the clear register
task automatic limit_checks();
  int                                         e0;
  clk_mon_reg_pkg::clk_mon_state_e            st;
  logic                                       flt;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] cnt;
  e0 = err_cnt;
  write_reg(clk_mon_reg_pkg::addr_limit_min, exp_sample - 10);
  write_reg(clk_mon_reg_pkg::addr_limit_max, exp_sample + 10);
  wait_samples(1);
  read_status(st, flt, cnt);
  expect_state("state", st, clk_mon_reg_pkg::st_locked);
  expect_flag("fault", fault, 1'b0);
  // maximum below the measured value
  write_reg(clk_mon_reg_pkg::addr_limit_max, exp_sample - 50);
  wait_samples(1);
  read_status(st, flt, cnt);
  expect_state("state", st, clk_mon_reg_pkg::st_fault);
  expect_flag("status fault", flt, 1'b1);
  expect_flag("fault", fault, 1'b1);
  write_reg(clk_mon_reg_pkg::addr_limit_max, exp_sample + 10);
  write_reg(clk_mon_reg_pkg::addr_clear, '0);
  wait_samples(1);
  read_status(st, flt, cnt);
  expect_state("state", st, clk_mon_reg_pkg::st_locked);
  expect_flag("status fault", flt, 1'b0);
  expect_flag("fault", fault, 1'b0);
  close_test("limits", e0);
endtask

// gated d_clk trips the watchdog, restart and clear recover
task automatic stopped_clock();
  int                                         e0;
  clk_mon_reg_pkg::clk_mon_state_e            st;
  logic                                       flt;
  logic [clk_mon_cfg_pkg::samp_cnt_width-1:0] cnt;
  e0 = err_cnt;
  @(negedge up_clk);
  d_clk_en = 1'b0;
  wait_state(clk_mon_reg_pkg::st_lost, time'(4 * win_len * up_period));
  read_status(st, flt, cnt);
  expect_state("state", st, clk_mon_reg_pkg::st_lost);
  expect_flag("fault", fault, 1'b1);
  @(negedge up_clk);
  d_clk_en = 1'b1;
  // first window after restart may be short
  wait_samples(2);
  write_reg(clk_mon_reg_pkg::addr_clear, '0);
  wait_samples(1);
  read_status(st, flt, cnt);
  expect_state("state", st, clk_mon_reg_pkg::st_locked);
  expect_flag("fault", fault, 1'b0);
  close_test("stopped clock", e0);
endtask

`endif

// File: verification/tb_clk_mon_top.sv
// clock monitor testbench top
// clocks, reset, DUT instance and the directed test sequence

`timescale 1ns/1ps
`default_nettype none

module tb_clk_mon_top;

  // ************************************************
  // timing and expected values
  // ************************************************

  // clock periods in ns
  localparam int d_period = 100;
  localparam int up_period = 40;

  // window length in up_clk cycles
  localparam int win_len = (2 ** clk_mon_cfg_pkg::win_width) - 1;
  // d_clk edges expected in one window
  localparam int exp_sample = win_len * up_period / d_period;
  // window edges and synchronizer phase shift the count by a couple of edges
  localparam int sample_tol = 2;

  // clocks and reset
  logic d_clk;
  logic d_clk_en;
  logic up_clk;
  logic d_rst;

  // register port
  logic                                   wr;
  logic                                   rd;
  clk_mon_reg_pkg::clk_mon_addr_e         addr;
  logic [clk_mon_reg_pkg::data_width-1:0] wdata;
  logic [clk_mon_reg_pkg::data_width-1:0] rdata;
  logic                                   rd_ack;
  logic                                   fault;

  // bookkeeping
  int err_cnt;
  int test_cnt;
  int test_fail;

  `include "tb_clk_mon_tasks.svh"

  clk_mon_top dut (
    .d_clk(d_clk), .d_rst(d_rst), .up_clk(up_clk),
    .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
    .rdata(rdata), .rd_ack(rd_ack), .fault(fault)
  );

  // measured clock, parks low while disabled
  always #(d_period / 2) d_clk = d_clk_en ? ~d_clk : 1'b0;

  // processor clock
  always #(up_period / 2) up_clk = ~up_clk;

  initial begin
    d_clk = 1'b0;
    d_clk_en = 1'b1;
    up_clk = 1'b0;
    d_rst = 1'b1;
    wr = 1'b0;
    rd = 1'b0;
    addr = clk_mon_reg_pkg::addr_count;
    wdata = '0;
    err_cnt = 0;
    test_cnt = 0;
    test_fail = 0;

    // reset held for four d_clk cycles
    repeat (4) @(negedge d_clk);
    d_rst = 1'b0;
    // up_rst releases a couple of up_clk edges later
    repeat (4) @(negedge up_clk);

    reset_values();
    measure_window();
    history_entries();
    limit_checks();
    stopped_clock();

    $display("tests run %0d, tests with errors %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: clk_mon.f
+incdir+include
src/clk_mon_cfg_pkg.sv
src/clk_mon_reg_pkg.sv
src/clk_mon_counter.sv
src/clk_mon_history.sv
src/clk_mon_checker.sv
src/clk_mon_regs.sv
src/clk_mon_top.sv
verification/tb_clk_mon_top.sv
